// File: list.f
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
main_fsm.sv
alu_decoder.sv
imm_extend.sv
control_unit.sv
control_unit_chk.sv
tb_control_unit.sv

// File: Bender.yml
package:
  name: control_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_ctrl_pkg.sv
      - main_fsm.sv
      - alu_decoder.sv
      - imm_extend.sv
      - control_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - control_unit_chk.sv
      - tb_control_unit.sv

// File: tb_control_unit.sv
`default_nettype none
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module tb_control_unit import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

    localparam int PERIOD    = 40;
    localparam int BATCHES   = 4;
    localparam int BATCH_LEN = 50;
    localparam int TIMEOUT   = (BATCHES * BATCH_LEN * 40 + 32) * PERIOD;

    typedef enum {
        m_fetch, m_decode, m_addr, m_read, m_memwb, m_write, m_exec,
        m_aluwb, m_jal, m_jalr, m_branch, m_mul, m_mulwb
    } mstate_e;

    logic clk, rst_n, mem_ready, alu_ready, mul_ready, zero;
    logic [`RV_XLEN-1:0] rdata, imm_ext;
    logic mem_valid, alu_valid, mul_valid, adr_src, ir_write, pc_write;
    logic reg_write, mem_write, alu_out_write;
    src_a_e    src_a;
    src_b_e    src_b;
    result_e   result_src;
    imm_src_e  imm_src;
    alu_ctrl_e alu_ctrl;

    logic [53:0] outs, prev_outs;  // all outputs packed for the stall hold check
    logic        prev_stall;
    logic [15:0] lfsr;
    mstate_e     mstate;
    logic [31:0] ir_model;
    int test_errs, total_errs, n_tests, n_pass;

    assign outs = {mem_valid, alu_valid, mul_valid, adr_src, ir_write, pc_write, reg_write,
                   mem_write, alu_out_write, src_a, src_b, result_src, imm_src, alu_ctrl,
                   imm_ext};

    control_unit uut (
        .clk (clk), .rst_n (rst_n), .rdata (rdata),
        .mem_ready (mem_ready), .alu_ready (alu_ready), .mul_ready (mul_ready),
        .zero (zero), .mem_valid (mem_valid), .alu_valid (alu_valid),
        .mul_valid (mul_valid), .adr_src (adr_src), .ir_write (ir_write),
        .pc_write (pc_write), .reg_write (reg_write), .mem_write (mem_write),
        .alu_out_write (alu_out_write), .src_a (src_a), .src_b (src_b),
        .result_src (result_src), .imm_src (imm_src), .alu_ctrl (alu_ctrl),
        .imm_ext (imm_ext)
    );

    bind control_unit control_unit_chk u_chk (
        .clk (clk), .rst_n (rst_n), .mem_valid (mem_valid), .alu_valid (alu_valid),
        .mul_valid (mul_valid), .ir_write (ir_write), .mem_write (mem_write),
        .reg_write (reg_write)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // galois lfsr stepped once per taken bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] draw_instr();
        logic [6:0]  opcodes [9] = '{7'b0000011, 7'b0100011, 7'b0110011, 7'b0010011,
                                     7'b1101111, 7'b1100111, 7'b1100011, 7'b0110111,
                                     7'b0010111};
        logic [31:0] pick, hi;
        pick = rand_bits(4) % 9;
        hi   = rand_bits(25);
        return {hi[24:0], opcodes[pick]};
    endfunction

    // ready that the state waits on (1 where it never stalls)
    function automatic logic ready_for(mstate_e s);
        case (s)
            m_fetch:                   return mem_ready && alu_ready;
            m_read, m_write:           return mem_ready;
            m_mul:                     return mul_ready;
            m_memwb, m_aluwb, m_mulwb: return 1'b1;
            default:                   return alu_ready;
        endcase
    endfunction

    function automatic mstate_e path_next(mstate_e s, logic [31:0] w);
        case (s)
            m_fetch:  return m_decode;
            m_decode: begin
                case (w[6:0])
                    7'b0000011, 7'b0100011:             return m_addr;
                    7'b0110011: return (`RV_HAS_MUL && w[25]) ? m_mul : m_exec;
                    7'b0010011, 7'b0110111, 7'b0010111: return m_exec;
                    7'b1101111:                         return m_jal;
                    7'b1100111:                         return m_jalr;
                    7'b1100011:                         return m_branch;
                    default:                            return m_fetch;
                endcase
            end
            m_addr:        return (w[6:0] == 7'b0000011) ? m_read : m_write;
            m_read:        return m_memwb;
            m_exec, m_jal: return m_aluwb;
            m_jalr:        return m_jal;
            m_mul:         return m_mulwb;
            default:       return m_fetch;  // write, branch, writebacks
        endcase
    endfunction

    function automatic imm_src_e model_fmt(logic [31:0] w);
        case (w[6:0])
            7'b0100011:             return imm_s;
            7'b1100011:             return imm_b;
            7'b0110111, 7'b0010111: return imm_u;
            7'b1101111:             return imm_j;
            default:                return imm_i;
        endcase
    endfunction

    // immediates rebuilt from raw bit positions of the ISA
    function automatic logic [31:0] model_imm(logic [31:0] w);
        case (model_fmt(w))
            imm_s:   return {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b:   return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_u:   return {w[31:12], 12'b0};
            imm_j:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic alu_ctrl_e model_alu(logic [31:0] w);
        case (w[6:0])
            7'b0110111: return alu_pass_b;  // lui
            7'b0010111: return alu_add;     // auipc
            default: ;
        endcase
        case (w[14:12])
            3'd0:    return (w[5] && w[30]) ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return w[30] ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // operand A wherever the ALU or multiplier is busy
    function automatic src_a_e model_src_a(mstate_e s, logic [31:0] w);
        case (s)
            m_fetch:         return src_a_pc;
            m_decode, m_jal: return src_a_old_pc;
            m_exec: begin
                case (w[6:0])
                    7'b0110111: return src_a_zero;    // lui
                    7'b0010111: return src_a_old_pc;  // auipc
                    default:    return src_a_rs1;
                endcase
            end
            default:         return src_a_rs1;  // addr, jalr, branch, mul
        endcase
    endfunction

    function automatic src_b_e model_src_b(mstate_e s, logic [31:0] w);
        case (s)
            m_fetch, m_jal:           return src_b_const4;  // pc + 4 and link
            m_decode, m_addr, m_jalr: return src_b_imm;
            m_exec:                   return (w[6:0] == 7'b0110011) ? src_b_rs2 : src_b_imm;
            default:                  return src_b_rs2;  // branch compare, mul
        endcase
    endfunction

    function automatic result_e model_res(mstate_e s);
        case (s)
            m_memwb: return res_mem_data;
            m_mulwb: return res_mul_out;
            default: return res_alu_out;  // data address, jump and branch targets, aluwb
        endcase
    endfunction

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_cycle(input mstate_e s, input logic [31:0] w);
        logic exp_ir, exp_mem, exp_alu;
        exp_ir  = (s == m_fetch) && ready_for(s);
        exp_mem = s inside {m_fetch, m_read, m_write, m_memwb, m_aluwb, m_mulwb};
        exp_alu = s inside {m_fetch, m_decode, m_addr, m_jalr, m_exec, m_jal, m_branch};
        check_val($sformatf("%s mem_valid", s.name()), mem_valid, exp_mem);
        check_val($sformatf("%s alu_valid", s.name()), alu_valid, exp_alu);
        check_val($sformatf("%s mul_valid", s.name()), mul_valid, s == m_mul);
        check_val($sformatf("%s adr_src", s.name()), adr_src, s inside {m_read, m_write});
        check_val($sformatf("%s ir_write", s.name()), ir_write, exp_ir);
        check_val($sformatf("%s pc_write", s.name()), pc_write,
                  exp_ir || s == m_jal || (s == m_branch && alu_ready && zero));
        check_val($sformatf("%s reg_write", s.name()), reg_write,
                  s inside {m_memwb, m_aluwb, m_mulwb});
        check_val($sformatf("%s mem_write", s.name()), mem_write, s == m_write);
        check_val($sformatf("%s alu_out_write", s.name()), alu_out_write, !exp_mem);
        if (exp_alu || s == m_mul) begin
            check_val($sformatf("%s src_a", s.name()), src_a, model_src_a(s, w));
            check_val($sformatf("%s src_b", s.name()), src_b, model_src_b(s, w));
        end
        if (s == m_decode) begin
            check_val("imm_src", imm_src, model_fmt(w));
            check_val("imm_ext", imm_ext, model_imm(w));
        end
        if (s == m_exec)
            check_val("exec alu_ctrl", alu_ctrl, model_alu(w));
        if (s == m_branch)
            check_val("branch alu_ctrl", alu_ctrl, alu_sub);
        if (s inside {m_read, m_write, m_memwb, m_aluwb, m_jal, m_branch, m_mulwb})
            check_val($sformatf("%s result_src", s.name()), result_src, model_res(s));
        if ((mem_write && reg_write) || (mul_valid && alu_valid) || (ir_write && !mem_valid)) begin
            $display("strobe exclusion broken at t=%0t in state %s", $time, s.name());
            test_errs++;
        end
    endtask

    // one instruction from its fetch until the model is back in fetch
    task automatic run_instr();
        logic [31:0] w;
        logic        stall;
        mstate_e     nxt;
        w = draw_instr();
        do begin
            @(negedge clk);
            rdata     = w;
            mem_ready = rand_bits(2) != 0;
            alu_ready = rand_bits(2) != 0;
            mul_ready = rand_bits(2) != 0;
            zero      = rand_bits(1) != 0;
            #(PERIOD / 4);
            check_cycle(mstate, ir_model);
            stall = !ready_for(mstate);
            if (stall && prev_stall)
                check_val($sformatf("%s outputs during stall", mstate.name()), outs, prev_outs);
            prev_stall = stall;
            prev_outs  = outs;
            nxt = stall ? mstate : path_next(mstate, ir_model);
            if (mstate == m_fetch && !stall)
                ir_model = w;
            @(posedge clk);
            mstate = nxt;
        end while (mstate != m_fetch);
    endtask

    task automatic end_test(input string name);
        $display("test %-16s : %s, %0d errors", name, (test_errs == 0) ? "ok" : "bad",
                 test_errs);
        n_tests++;
        if (test_errs == 0)
            n_pass++;
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the controller stopped making progress before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        lfsr       = 16'd44844;
        rst_n      = 1'b0;
        rdata      = '0;
        mem_ready  = 1'b0;
        alu_ready  = 1'b0;
        mul_ready  = 1'b0;
        zero       = 1'b0;
        mstate     = m_fetch;
        ir_model   = '0;
        prev_stall = 1'b0;
        prev_outs  = '0;
        test_errs  = 0;
        total_errs = 0;
        n_tests    = 0;
        n_pass     = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // fetch must wait while memory is not ready
        repeat (3) begin
            alu_ready = 1'b1;
            #(PERIOD / 4);
            check_val("reset mem_valid", mem_valid, 1'b1);
            check_val("reset adr_src", adr_src, 1'b0);
            check_val("reset ir_write", ir_write, 1'b0);
            check_val("reset pc_write", pc_write, 1'b0);
            check_val("reset reg_write", reg_write, 1'b0);
            check_val("reset mem_write", mem_write, 1'b0);
            check_val("reset mul_valid", mul_valid, 1'b0);
            @(negedge clk);
        end
        end_test("reset");
        for (int b = 0; b < BATCHES; b++) begin
            repeat (BATCH_LEN) run_instr();
            end_test($sformatf("random batch %0d", b));
        end
        $display("tests %0d, passed %0d, errors %0d", n_tests, n_pass, total_errs);
        if (total_errs == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: control_unit_chk.sv
`default_nettype none
`timescale 1ns/100ps

module control_unit_chk (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic mem_valid,
    input wire logic alu_valid,
    input wire logic mul_valid,
    input wire logic ir_write,
    input wire logic mem_write,
    input wire logic reg_write
);

    // a store and a register writeback never share a cycle
    a_store_vs_writeback: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_write && reg_write)
    ) else $error("mem_write and reg_write high in the same cycle");

    a_mul_vs_alu: assert property (
        @(posedge clk) disable iff (!rst_n) !(mul_valid && alu_valid)
    ) else $error("mul_valid and alu_valid high in the same cycle");

    // the IR only loads a word that memory is delivering
    a_ir_needs_mem: assert property (
        @(posedge clk) disable iff (!rst_n) ir_write |-> mem_valid
    ) else $error("ir_write high without mem_valid");

endmodule

`default_nettype wire

// File: control_unit.sv
`default_nettype none
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module control_unit import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [`RV_XLEN-1:0] rdata,
    input  wire logic                mem_ready,
    input  wire logic                alu_ready,
    input  wire logic                mul_ready,
    input  wire logic                zero,
    output logic                     mem_valid,
    output logic                     alu_valid,
    output logic                     mul_valid,
    output logic                     adr_src,
    output logic                     ir_write,
    output logic                     pc_write,
    output logic                     reg_write,
    output logic                     mem_write,
    output logic                     alu_out_write,
    output src_a_e                   src_a,
    output src_b_e                   src_b,
    output result_e                  result_src,
    output imm_src_e                 imm_src,
    output alu_ctrl_e                alu_ctrl,
    output logic [`RV_XLEN-1:0]      imm_ext
);

    rv_instr_u  instr_q;  // instruction register
    alu_class_e alu_class;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            instr_q <= '0;
        else if (ir_write)
            instr_q <= rdata;
    end

    main_fsm u_main_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (opcode_e'(instr_q.r.opcode)),
        .funct7b0      (instr_q.r.funct7[0]),  // M extension marker
        .mem_ready     (mem_ready),
        .alu_ready     (alu_ready),
        .mul_ready     (mul_ready),
        .zero          (zero),
        .mem_valid     (mem_valid),
        .alu_valid     (alu_valid),
        .mul_valid     (mul_valid),
        .adr_src       (adr_src),
        .ir_write      (ir_write),
        .pc_write      (pc_write),
        .reg_write     (reg_write),
        .mem_write     (mem_write),
        .alu_out_write (alu_out_write),
        .src_a         (src_a),
        .src_b         (src_b),
        .result_src    (result_src),
        .imm_src       (imm_src),
        .alu_class     (alu_class)
    );

    alu_decoder u_alu_decoder (
        .alu_class (alu_class),
        .funct3    (instr_q.r.funct3),
        .funct7b5  (instr_q.r.funct7[5]),
        .op_b5     (instr_q.r.opcode[5]),
        .alu_ctrl  (alu_ctrl)
    );

    imm_extend u_imm_extend (
        .instr   (instr_q),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

endmodule

`default_nettype wire

// File: imm_extend.sv
`default_nettype none
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module imm_extend import rv_isa_pkg::*; (
    input  wire rv_instr_u            instr,
    input  wire imm_src_e             imm_src,
    output logic [`RV_XLEN-1:0]       imm_ext
);

    logic signed [31:0] imm_raw;  // 32 bit immediate before widening

    always_comb begin
        case (imm_src)
            imm_i: imm_raw = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            imm_s: imm_raw = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5,
                              instr.s.imm_4_0};
            imm_b: imm_raw = {{20{instr.b.imm_12}}, instr.b.imm_11,
                              instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            imm_u: imm_raw = {instr.u.imm_31_12, 12'b0};
            imm_j: imm_raw = {{12{instr.j.imm_20}}, instr.j.imm_19_12,
                              instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default: imm_raw = '0;
        endcase
    end

    // signed cast carries bit 31 into any wider word
    assign imm_ext = `RV_XLEN'(imm_raw);

endmodule

`default_nettype wire

// File: alu_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module alu_decoder import rv_ctrl_pkg::*; (
    input  wire alu_class_e alu_class,
    input  wire logic [2:0] funct3,
    input  wire logic       funct7b5,
    input  wire logic       op_b5,     // set for register-register ops
    output alu_ctrl_e       alu_ctrl
);

    always_comb begin
        case (alu_class)
            cls_add:    alu_ctrl = alu_add;
            cls_branch: alu_ctrl = alu_sub;  // compare via zero flag
            cls_lui:    alu_ctrl = alu_pass_b;
            default: begin
                case (funct3)
                    3'd0:    alu_ctrl = (op_b5 && funct7b5) ? alu_sub : alu_add;
                    3'd1:    alu_ctrl = alu_sll;
                    3'd2:    alu_ctrl = alu_slt;
                    3'd3:    alu_ctrl = alu_sltu;
                    3'd4:    alu_ctrl = alu_xor;
                    3'd5:    alu_ctrl = funct7b5 ? alu_sra : alu_srl;
                    3'd6:    alu_ctrl = alu_or;
                    default: alu_ctrl = alu_and;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// File: main_fsm.sv
`default_nettype none
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module main_fsm import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire opcode_e    op,
    input  wire logic       funct7b0,
    input  wire logic       mem_ready,
    input  wire logic       alu_ready,
    input  wire logic       mul_ready,
    input  wire logic       zero,
    output logic            mem_valid,
    output logic            alu_valid,
    output logic            mul_valid,
    output logic            adr_src,    // 0 pc, 1 registered result
    output logic            ir_write,
    output logic            pc_write,
    output logic            reg_write,
    output logic            mem_write,
    output logic            alu_out_write,
    output src_a_e          src_a,
    output src_b_e          src_b,
    output result_e         result_src,
    output imm_src_e        imm_src,
    output alu_class_e      alu_class
);

    typedef enum logic [3:0] {
        s_fetch, s_decode, s_addr, s_read, s_memwb, s_write, s_exec,
        s_aluwb, s_jal, s_jalr, s_branch, s_mul, s_mulwb
    } state_e;

    state_e state, next_state;
    logic   fetch_done;

    // word arrives and pc + 4 is ready in the same cycle
    assign fetch_done    = mem_ready & alu_ready;
    assign alu_out_write = ~mem_valid;  // ALUOut frozen while memory is addressed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= s_fetch;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;  // stall by default
        case (state)
            s_fetch:  if (fetch_done) next_state = s_decode;
            s_decode: begin
                if (alu_ready) begin
                    case (op)
                        op_load, op_store:           next_state = s_addr;
                        op_op:                       next_state = (`RV_HAS_MUL && funct7b0) ?
                                                                  s_mul : s_exec;
                        op_op_imm, op_lui, op_auipc: next_state = s_exec;
                        op_jal:                      next_state = s_jal;
                        op_jalr:                     next_state = s_jalr;
                        op_branch:                   next_state = s_branch;
                        default:                     next_state = s_fetch;  // illegal
                    endcase
                end
            end
            s_addr:   if (alu_ready) next_state = (op == op_load) ? s_read : s_write;
            s_read:   if (mem_ready) next_state = s_memwb;
            s_write:  if (mem_ready) next_state = s_fetch;
            s_exec:   if (alu_ready) next_state = s_aluwb;
            s_jalr:   if (alu_ready) next_state = s_jal;
            s_jal:    if (alu_ready) next_state = s_aluwb;
            s_branch: if (alu_ready) next_state = s_fetch;
            s_mul:    if (mul_ready) next_state = s_mulwb;
            s_memwb, s_aluwb, s_mulwb: next_state = s_fetch;
            default:  next_state = s_fetch;
        endcase
    end

    always_comb begin
        case (op)
            op_store:          imm_src = imm_s;
            op_branch:         imm_src = imm_b;
            op_lui, op_auipc:  imm_src = imm_u;
            op_jal:            imm_src = imm_j;
            default:           imm_src = imm_i;  // loads, op_imm, jalr
        endcase
    end

    always_comb begin
        mem_valid  = 1'b0;
        alu_valid  = 1'b0;
        mul_valid  = 1'b0;
        adr_src    = 1'b0;
        ir_write   = 1'b0;
        pc_write   = 1'b0;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        src_a      = src_a_pc;
        src_b      = src_b_rs2;
        result_src = res_alu_result;
        alu_class  = cls_add;
        case (state)
            s_fetch: begin
                // ir <- mem[pc], pc <- pc + 4
                mem_valid = 1'b1;
                alu_valid = 1'b1;
                src_b     = src_b_const4;
                ir_write  = fetch_done;
                pc_write  = fetch_done;
            end
            s_decode: begin
                // branch/jump target into ALUOut
                alu_valid = 1'b1;
                src_a     = src_a_old_pc;
                src_b     = src_b_imm;
            end
            s_addr, s_jalr: begin
                alu_valid = 1'b1;  // rs1 + imm
                src_a     = src_a_rs1;
                src_b     = src_b_imm;
            end
            s_read: begin
                mem_valid  = 1'b1;
                adr_src    = 1'b1;
                result_src = res_alu_out;
            end
            s_write: begin
                mem_valid  = 1'b1;
                mem_write  = 1'b1;
                adr_src    = 1'b1;
                result_src = res_alu_out;
            end
            s_memwb: begin
                mem_valid  = 1'b1;
                reg_write  = 1'b1;
                result_src = res_mem_data;
            end
            s_exec: begin
                alu_valid = 1'b1;
                case (op)
                    op_lui:   src_a = src_a_zero;
                    op_auipc: src_a = src_a_old_pc;
                    default:  src_a = src_a_rs1;
                endcase
                src_b     = (op == op_op) ? src_b_rs2 : src_b_imm;
                case (op)
                    op_lui:   alu_class = cls_lui;
                    op_auipc: alu_class = cls_add;
                    default:  alu_class = cls_arith_logic;
                endcase
            end
            s_aluwb: begin
                mem_valid  = 1'b1;
                reg_write  = 1'b1;
                result_src = res_alu_out;
            end
            s_jal: begin
                // pc <- target, ALUOut <- old pc + 4 for the link
                alu_valid  = 1'b1;
                src_a      = src_a_old_pc;
                src_b      = src_b_const4;
                result_src = res_alu_out;
                pc_write   = 1'b1;
            end
            s_branch: begin
                alu_valid  = 1'b1;
                src_a      = src_a_rs1;
                alu_class  = cls_branch;
                result_src = res_alu_out;
                pc_write   = alu_ready & zero;  // taken only on equal compare
            end
            s_mul: begin
                mul_valid = 1'b1;
                src_a     = src_a_rs1;
            end
            s_mulwb: begin
                mem_valid  = 1'b1;
                reg_write  = 1'b1;
                result_src = res_mul_out;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // ALU operand A
    typedef enum logic [1:0] {
        src_a_pc     = 2'd0,
        src_a_old_pc = 2'd1,  // pc of the instruction in the IR
        src_a_rs1    = 2'd2,
        src_a_zero   = 2'd3
    } src_a_e;

    // ALU operand B
    typedef enum logic [1:0] {
        src_b_rs2    = 2'd0,
        src_b_imm    = 2'd1,
        src_b_const4 = 2'd2
    } src_b_e;

    // what goes back to pc and the register file
    typedef enum logic [1:0] {
        res_alu_result = 2'd0,  // straight from the ALU
        res_alu_out    = 2'd1,  // registered ALU result
        res_mem_data   = 2'd2,
        res_mul_out    = 2'd3
    } result_e;

    // coarse operation class from the sequencer
    typedef enum logic [1:0] {
        cls_add         = 2'd0,
        cls_branch      = 2'd1,
        cls_arith_logic = 2'd2,
        cls_lui         = 2'd3
    } alu_class_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_ctrl_e;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // anything outside these base opcodes decodes as illegal
    typedef enum logic [6:0] {
        op_load   = 7'b000_0011,
        op_store  = 7'b010_0011,
        op_op     = 7'b011_0011,  // register-register
        op_op_imm = 7'b001_0011,  // register-immediate
        op_jal    = 7'b110_1111,
        op_jalr   = 7'b110_0111,
        op_branch = 7'b110_0011,
        op_lui    = 7'b011_0111,
        op_auipc  = 7'b001_0111
    } opcode_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_src_e;

    // one instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;  // sits where rd would be
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

endpackage

`default_nettype wire

// File: riscv_cfg.svh
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// width of data words, fetched words and immediates
`define RV_XLEN 32

// M extension present
// funct7 bit 0 on an R-type word then selects the multiplier path
`define RV_HAS_MUL 1'b1

`endif
